/* mips_isa_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MIPS instruction set encodings for the single-cycle core
// opcode, funct and REGIMM codes plus the three views of one word
// imported by the decoder, the fetch unit and the core top level
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package mips_isa_pkg;

   // primary opcodes, bits 31 to 26
   localparam logic [5:0] OP_RTYPE  = 6'h00;
   localparam logic [5:0] OP_REGIMM = 6'h01;
   localparam logic [5:0] OP_J      = 6'h02;
   localparam logic [5:0] OP_JAL    = 6'h03;
   localparam logic [5:0] OP_BEQ    = 6'h04;
   localparam logic [5:0] OP_BNE    = 6'h05;
   localparam logic [5:0] OP_BLEZ   = 6'h06;
   localparam logic [5:0] OP_BGTZ   = 6'h07;
   localparam logic [5:0] OP_ADDIU  = 6'h09;
   localparam logic [5:0] OP_SLTI   = 6'h0a;
   localparam logic [5:0] OP_ANDI   = 6'h0c;
   localparam logic [5:0] OP_ORI    = 6'h0d;
   localparam logic [5:0] OP_XORI   = 6'h0e;
   localparam logic [5:0] OP_LUI    = 6'h0f;
   localparam logic [5:0] OP_LB     = 6'h20;
   localparam logic [5:0] OP_LW     = 6'h23;
   localparam logic [5:0] OP_LBU    = 6'h24;
   localparam logic [5:0] OP_SB     = 6'h28;
   localparam logic [5:0] OP_SW     = 6'h2b;

   // funct field of the R-type group
   localparam logic [5:0] FN_SLL     = 6'h00;
   localparam logic [5:0] FN_SRL     = 6'h02;
   localparam logic [5:0] FN_SRA     = 6'h03;
   localparam logic [5:0] FN_JR      = 6'h08;
   localparam logic [5:0] FN_SYSCALL = 6'h0c;
   localparam logic [5:0] FN_ADDU    = 6'h21;
   localparam logic [5:0] FN_SUBU    = 6'h23;
   localparam logic [5:0] FN_AND     = 6'h24;
   localparam logic [5:0] FN_OR      = 6'h25;
   localparam logic [5:0] FN_XOR     = 6'h26;
   localparam logic [5:0] FN_NOR     = 6'h27;
   localparam logic [5:0] FN_SLT     = 6'h2a;

   // rt field picks the branch inside the REGIMM group
   localparam logic [4:0] RT_BLTZ = 5'h00;
   localparam logic [4:0] RT_BGEZ = 5'h01;

   // first fetch address after reset
   localparam logic [31:0] TEXT_START = 32'h0040_0000;
   // jal links into $ra
   localparam logic [4:0] REG_RA = 5'd31;

   // one instruction word seen as R, I or J format
   typedef union packed {
      struct packed {
         logic [5:0] op;
         logic [4:0] rs;
         logic [4:0] rt;
         logic [4:0] rd;
         logic [4:0] shamt;
         logic [5:0] funct;
      } r;
      struct packed {
         logic [5:0]  op;
         logic [4:0]  rs;
         logic [4:0]  rt;
         logic [15:0] imm;
      } i;
      struct packed {
         logic [5:0]  op;
         logic [25:0] target;
      } j;
   } inst_u;

endpackage

/* core_ctrl_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// control encodings passed from the decoder to the datapath blocks
// widths are given as localparams so ports can be sized by scope
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package core_ctrl_pkg;

   localparam int ALU_W = 4;
   localparam int BR_W  = 3;
   localparam int PC_W  = 2;
   localparam int WB_W  = 2;
   localparam int SZ_W  = 2;

   // ALU operation select
   localparam logic [ALU_W-1:0] ALU_ADD = 4'd0;
   localparam logic [ALU_W-1:0] ALU_SUB = 4'd1;
   localparam logic [ALU_W-1:0] ALU_AND = 4'd2;
   localparam logic [ALU_W-1:0] ALU_OR  = 4'd3;
   localparam logic [ALU_W-1:0] ALU_XOR = 4'd4;
   localparam logic [ALU_W-1:0] ALU_NOR = 4'd5;
   localparam logic [ALU_W-1:0] ALU_SLT = 4'd6;
   localparam logic [ALU_W-1:0] ALU_SLL = 4'd7;
   localparam logic [ALU_W-1:0] ALU_SRL = 4'd8;
   localparam logic [ALU_W-1:0] ALU_SRA = 4'd9;
   localparam logic [ALU_W-1:0] ALU_LUI = 4'd10;

   // branch condition, none means never taken
   localparam logic [BR_W-1:0] BR_NONE = 3'd0;
   localparam logic [BR_W-1:0] BR_EQ   = 3'd1;
   localparam logic [BR_W-1:0] BR_NE   = 3'd2;
   localparam logic [BR_W-1:0] BR_LEZ  = 3'd3;
   localparam logic [BR_W-1:0] BR_GTZ  = 3'd4;
   localparam logic [BR_W-1:0] BR_LTZ  = 3'd5;
   localparam logic [BR_W-1:0] BR_GEZ  = 3'd6;

   // next pc source
   localparam logic [PC_W-1:0] PC_SEQ    = 2'd0;
   localparam logic [PC_W-1:0] PC_BRANCH = 2'd1;
   localparam logic [PC_W-1:0] PC_JUMP   = 2'd2;
   localparam logic [PC_W-1:0] PC_REG    = 2'd3;

   // write-back source
   localparam logic [WB_W-1:0] WB_ALU  = 2'd0;
   localparam logic [WB_W-1:0] WB_LOAD = 2'd1;
   localparam logic [WB_W-1:0] WB_LINK = 2'd2;

   // load and store access size
   localparam logic [SZ_W-1:0] SZ_NONE = 2'd0;
   localparam logic [SZ_W-1:0] SZ_BYTE = 2'd1;
   localparam logic [SZ_W-1:0] SZ_WORD = 2'd2;

endpackage

/* fetch_unit.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// program counter, next-pc selection and halt register
// no delay slot, the pc moves straight to the selected target
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module fetch_unit (
   input  logic                           clk,
   input  logic                           rst_b,
   input  mips_isa_pkg::inst_u            inst,
   input  logic [31:0]                    imm_se,
   input  logic [31:0]                    rs_data,
   input  logic [core_ctrl_pkg::PC_W-1:0] pc_sel,
   input  logic                           branch_taken,
   input  logic                           stop,
   output logic [31:0]                    pc,
   output logic [31:0]                    pc_plus4,
   output logic                           halted
);
   import mips_isa_pkg::*;
   import core_ctrl_pkg::*;

   logic [31:0] br_target;
   logic [31:0] j_target;
   logic [31:0] next_pc;

   assign pc_plus4  = pc + 32'd4;
   // word offset relative to the following instruction
   assign br_target = pc_plus4 + {imm_se[29:0], 2'b00};
   // jump stays inside the current 256 MB region
   assign j_target  = {pc[31:28], inst.j.target, 2'b00};

   always_comb
   begin
      case (pc_sel)
         PC_BRANCH: next_pc = branch_taken ? br_target : pc_plus4;
         PC_JUMP:   next_pc = j_target;
         PC_REG:    next_pc = rs_data;
         default:   next_pc = pc_plus4;
      endcase
   end

   always_ff @(posedge clk or negedge rst_b)
   begin
      if (!rst_b)
      begin
         pc     <= TEXT_START;
         halted <= 1'b0;
      end
      else
      begin
         // halt is sticky until the next reset
         if (stop)
            halted <= 1'b1;
         // pc holds on the stopping instruction
         if (!(stop || halted))
            pc <= next_pc;
      end
   end

   // catches a jr to a misaligned register value
   assert property (@(posedge clk) disable iff (!rst_b) pc[1:0] == 2'b00)
      else $error("pc 0x%08h is not word aligned", pc);

endmodule

/* decode_ctrl.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// combinational decoder from instruction word to control codes
// also builds the extended immediate and the destination register
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module decode_ctrl (
   input  mips_isa_pkg::inst_u             inst,
   output logic [core_ctrl_pkg::ALU_W-1:0] alu_op,
   output logic [core_ctrl_pkg::BR_W-1:0]  br_cond,
   output logic [core_ctrl_pkg::PC_W-1:0]  pc_sel,
   output logic [core_ctrl_pkg::WB_W-1:0]  wb_sel,
   output logic [core_ctrl_pkg::SZ_W-1:0]  ld_size,
   output logic [core_ctrl_pkg::SZ_W-1:0]  st_size,
   output logic                            use_imm,
   output logic [31:0]                     imm_ext,
   output logic                            reg_we,
   output logic [4:0]                      wr_reg,
   output logic                            stop
);
   import mips_isa_pkg::*;
   import core_ctrl_pkg::*;

   logic            we_raw;
   logic            zero_ext;
   logic            sys;
   logic            rsvd;

   always_comb
   begin
      // defaults describe an I-type add writing rt
      alu_op   = ALU_ADD;
      br_cond  = BR_NONE;
      pc_sel   = PC_SEQ;
      wb_sel   = WB_ALU;
      ld_size  = SZ_NONE;
      st_size  = SZ_NONE;
      use_imm  = 1'b1;
      zero_ext = 1'b0;
      we_raw   = 1'b0;
      wr_reg   = inst.i.rt;
      sys      = 1'b0;
      rsvd     = 1'b0;
      case (inst.r.op)
         OP_RTYPE:
         begin
            use_imm = 1'b0;
            we_raw  = 1'b1;
            wr_reg  = inst.r.rd;
            case (inst.r.funct)
               FN_ADDU: alu_op = ALU_ADD;
               FN_SUBU: alu_op = ALU_SUB;
               FN_AND:  alu_op = ALU_AND;
               FN_OR:   alu_op = ALU_OR;
               FN_XOR:  alu_op = ALU_XOR;
               FN_NOR:  alu_op = ALU_NOR;
               FN_SLT:  alu_op = ALU_SLT;
               FN_SLL:  alu_op = ALU_SLL;
               FN_SRL:  alu_op = ALU_SRL;
               FN_SRA:  alu_op = ALU_SRA;
               FN_JR:
               begin
                  pc_sel = PC_REG;
                  we_raw = 1'b0;
               end
               FN_SYSCALL: sys = 1'b1;
               // unknown funct stops like an unknown opcode
               default: rsvd = 1'b1;
            endcase
         end
         OP_ADDIU: we_raw = 1'b1;
         OP_SLTI:
         begin
            alu_op = ALU_SLT;
            we_raw = 1'b1;
         end
         OP_ANDI, OP_ORI, OP_XORI, OP_LUI:
         begin
            zero_ext = 1'b1;
            we_raw   = 1'b1;
            case (inst.i.op)
               OP_ANDI: alu_op = ALU_AND;
               OP_ORI:  alu_op = ALU_OR;
               OP_XORI: alu_op = ALU_XOR;
               default: alu_op = ALU_LUI;
            endcase
         end
         OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ, OP_REGIMM:
         begin
            // compare against rt, the zero tests ignore op_b
            use_imm = 1'b0;
            alu_op  = ALU_SUB;
            pc_sel  = PC_BRANCH;
            case (inst.i.op)
               OP_BEQ:  br_cond = BR_EQ;
               OP_BNE:  br_cond = BR_NE;
               OP_BLEZ: br_cond = BR_LEZ;
               OP_BGTZ: br_cond = BR_GTZ;
               default:
               begin
                  if (inst.i.rt == RT_BLTZ)
                     br_cond = BR_LTZ;
                  else if (inst.i.rt == RT_BGEZ)
                     br_cond = BR_GEZ;
                  else
                     rsvd = 1'b1;
               end
            endcase
         end
         OP_J: pc_sel = PC_JUMP;
         OP_JAL:
         begin
            pc_sel = PC_JUMP;
            wb_sel = WB_LINK;
            wr_reg = REG_RA;
            we_raw = 1'b1;
         end
         OP_LB, OP_LBU, OP_LW:
         begin
            wb_sel  = WB_LOAD;
            we_raw  = 1'b1;
            ld_size = (inst.i.op == OP_LW) ? SZ_WORD : SZ_BYTE;
         end
         // store opcodes never stop, so st_size needs no gating
         OP_SB: st_size = SZ_BYTE;
         OP_SW: st_size = SZ_WORD;
         default: rsvd = 1'b1;
      endcase
   end

   assign imm_ext = zero_ext ? {16'h0000, inst.i.imm} : {{16{inst.i.imm[15]}}, inst.i.imm};

   // a stopping instruction has no side effects
   assign stop    = sys | rsvd;
   assign reg_we  = we_raw & ~stop;

endmodule

/* reg_file.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 32 x 32 general purpose registers
// two asynchronous read ports and one write port at the clock edge
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module reg_file (
   input  logic        clk,
   input  logic        rst_b,
   input  logic [4:0]  rs_addr,
   input  logic [4:0]  rt_addr,
   input  logic [4:0]  wr_addr,
   input  logic [31:0] wr_data,
   input  logic        we,
   output logic [31:0] rs_data,
   output logic [31:0] rt_data
);

   logic [31:0] regs [32];

   always_ff @(posedge clk or negedge rst_b)
   begin
      if (!rst_b)
      begin
         for (int i = 0; i < 32; i++)
            regs[i] <= 32'h0;
      end
      // $zero never takes a write
      else if (we && (wr_addr != 5'd0))
         regs[wr_addr] <= wr_data;
   end

   // reads see the old value when reading the register being written
   assign rs_data = regs[rs_addr];
   assign rt_data = regs[rt_addr];

   // an X enable would corrupt state through the decoder
   assert property (@(posedge clk) disable iff (!rst_b) !$isunknown(we))
      else $error("register write enable is unknown");

endmodule

/* exec_alu.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// integer ALU with the branch comparator alongside
// purely combinational, result and branch decision in the same cycle
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module exec_alu (
   input  logic [31:0]                     op_a,
   input  logic [31:0]                     op_b,
   input  logic [4:0]                      shamt,
   input  logic [core_ctrl_pkg::ALU_W-1:0] alu_op,
   input  logic [core_ctrl_pkg::BR_W-1:0]  br_cond,
   output logic [31:0]                     result,
   output logic                            branch_taken
);
   import core_ctrl_pkg::*;

   always_comb
   begin
      case (alu_op)
         ALU_ADD: result = op_a + op_b;
         ALU_SUB: result = op_a - op_b;
         ALU_AND: result = op_a & op_b;
         ALU_OR:  result = op_a | op_b;
         ALU_XOR: result = op_a ^ op_b;
         ALU_NOR: result = ~(op_a | op_b);
         // signed compare for slt and slti
         ALU_SLT: result = {31'b0, $signed(op_a) < $signed(op_b)};
         // shifts act on rt, amount from the shamt field
         ALU_SLL: result = op_b << shamt;
         ALU_SRL: result = op_b >> shamt;
         ALU_SRA: result = $unsigned($signed(op_b) >>> shamt);
         ALU_LUI: result = {op_b[15:0], 16'h0000};
         default: result = op_a + op_b;
      endcase
   end

   // zero tests look at rs only
   always_comb
   begin
      case (br_cond)
         BR_EQ:   branch_taken = (op_a == op_b);
         BR_NE:   branch_taken = (op_a != op_b);
         BR_LEZ:  branch_taken = ($signed(op_a) <= 0);
         BR_GTZ:  branch_taken = ($signed(op_a) > 0);
         BR_LTZ:  branch_taken = op_a[31];
         BR_GEZ:  branch_taken = !op_a[31];
         default: branch_taken = 1'b0;
      endcase
   end

endmodule

/* mem_align.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// byte-lane alignment between the core and the data port
// big-endian lanes, byte offset 0 lives in bits 31 to 24
// mask bit n enables data bits 8n+7 to 8n, so offset 0 is mask 4'b1000
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module mem_align (
   input  logic [31:0]                    addr,
   input  logic [31:0]                    rt_data,
   input  logic [core_ctrl_pkg::SZ_W-1:0] st_size,
   input  logic [core_ctrl_pkg::SZ_W-1:0] ld_size,
   input  logic                           ld_signed,
   input  logic [31:0]                    mem_rdata,
   output logic [29:0]                    mem_addr,
   output logic [31:0]                    mem_wdata,
   output logic [3:0]                     mem_wmask,
   output logic [31:0]                    load_data
);
   import core_ctrl_pkg::*;

   logic [7:0] ld_byte;

   assign mem_addr = addr[31:2];

   // store side, byte copied to all lanes and the mask picks one
   always_comb
   begin
      case (st_size)
         SZ_BYTE:
         begin
            mem_wdata = {4{rt_data[7:0]}};
            mem_wmask = 4'b1000 >> addr[1:0];
         end
         SZ_WORD:
         begin
            mem_wdata = rt_data;
            mem_wmask = 4'b1111;
         end
         default:
         begin
            mem_wdata = rt_data;
            mem_wmask = 4'b0000;
         end
      endcase
   end

   // load side, lane selected by the low address bits
   always_comb
   begin
      case (addr[1:0])
         2'd0:    ld_byte = mem_rdata[31:24];
         2'd1:    ld_byte = mem_rdata[23:16];
         2'd2:    ld_byte = mem_rdata[15:8];
         default: ld_byte = mem_rdata[7:0];
      endcase
   end

   // word loads pass through untouched
   assign load_data = (ld_size == SZ_BYTE) ?
                      {{24{ld_signed & ld_byte[7]}}, ld_byte} : mem_rdata;

   // word accesses drop the low address bits, so they must be aligned
   always_comb
   begin
      assert final (addr[1:0] == 2'b00 ||
                    (st_size != SZ_WORD && ld_size != SZ_WORD))
         else $error("misaligned word access at 0x%08h", addr);
   end

endmodule

/* mips_core.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// single-cycle MIPS subset core, top level
// separate instruction and data ports, both read combinationally
// one instruction retires per clock until syscall or a reserved op
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module mips_core (
   input  logic        clk,
   input  logic        rst_b,
   output logic [29:0] inst_addr,
   input  logic [31:0] inst,
   output logic [29:0] mem_addr,
   output logic [31:0] mem_wdata,
   output logic [3:0]  mem_wmask,
   input  logic [31:0] mem_rdata,
   output logic        halted
);
   import mips_isa_pkg::*;
   import core_ctrl_pkg::*;

   inst_u              inst_w;
   logic [ALU_W-1:0]   alu_op;
   logic [BR_W-1:0]    br_cond;
   logic [PC_W-1:0]    pc_sel;
   logic [WB_W-1:0]    wb_sel;
   logic [SZ_W-1:0]    ld_size;
   logic [SZ_W-1:0]    st_size;
   logic [SZ_W-1:0]    st_size_run;
   logic               use_imm;
   logic [31:0]        imm_ext;
   logic               reg_we;
   logic [4:0]         wr_reg;
   logic               stop;
   logic [31:0]        pc;
   logic [31:0]        pc_plus4;
   logic [31:0]        rs_data;
   logic [31:0]        rt_data;
   logic [31:0]        alu_b;
   logic [31:0]        alu_result;
   logic               branch_taken;
   logic               ld_signed;
   logic [31:0]        load_data;
   logic [31:0]        wr_data;

   // raw word from instruction memory, viewed through the format union
   assign inst_w    = inst;
   assign inst_addr = pc[31:2];

   fetch_unit fetch_i (
      .clk          (clk),
      .rst_b        (rst_b),
      .inst         (inst_w),
      .imm_se       (imm_ext),
      .rs_data      (rs_data),
      .pc_sel       (pc_sel),
      .branch_taken (branch_taken),
      .stop         (stop),
      .pc           (pc),
      .pc_plus4     (pc_plus4),
      .halted       (halted)
   );

   decode_ctrl decode_i (
      .inst    (inst_w),
      .alu_op  (alu_op),
      .br_cond (br_cond),
      .pc_sel  (pc_sel),
      .wb_sel  (wb_sel),
      .ld_size (ld_size),
      .st_size (st_size),
      .use_imm (use_imm),
      .imm_ext (imm_ext),
      .reg_we  (reg_we),
      .wr_reg  (wr_reg),
      .stop    (stop)
   );

   reg_file regs_i (
      .clk     (clk),
      .rst_b   (rst_b),
      .rs_addr (inst_w.r.rs),
      .rt_addr (inst_w.r.rt),
      .wr_addr (wr_reg),
      .wr_data (wr_data),
      .we      (reg_we),
      .rs_data (rs_data),
      .rt_data (rt_data)
   );

   // immediate replaces rt for I-type ALU ops and address generation
   assign alu_b = use_imm ? imm_ext : rt_data;

   exec_alu alu_i (
      .op_a         (rs_data),
      .op_b         (alu_b),
      .shamt        (inst_w.r.shamt),
      .alu_op       (alu_op),
      .br_cond      (br_cond),
      .result       (alu_result),
      .branch_taken (branch_taken)
   );

   // lbu is the only unsigned load in the subset
   assign ld_signed = (inst_w.i.op != OP_LBU);
   // no store reaches memory while reset is held
   assign st_size_run = rst_b ? st_size : SZ_NONE;

   mem_align align_i (
      .addr      (alu_result),
      .rt_data   (rt_data),
      .st_size   (st_size_run),
      .ld_size   (ld_size),
      .ld_signed (ld_signed),
      .mem_rdata (mem_rdata),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_wmask (mem_wmask),
      .load_data (load_data)
   );

   // write-back select, jal links the address after itself
   always_comb
   begin
      case (wb_sel)
         WB_LOAD: wr_data = load_data;
         WB_LINK: wr_data = pc_plus4;
         default: wr_data = alu_result;
      endcase
   end

endmodule

/* tb_top.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the single-cycle MIPS subset core
// program, data and expected stores come from core_trace.txt
// every store is checked in order, then the halt cycle and the count
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_top;

   // characters that start a trace record
   localparam int CH_INST  = 73;
   localparam int CH_DATA  = 68;
   localparam int CH_STORE = 83;
   localparam int CH_COUNT = 78;
   localparam int CH_HASH  = 35;
   localparam int CH_NL    = 10;
   localparam int MAX_ST   = 64;

   logic        clk;
   logic        rst_b;
   logic [29:0] inst_addr;
   logic [31:0] inst;
   logic [29:0] mem_addr;
   logic [31:0] mem_wdata;
   logic [3:0]  mem_wmask;
   logic [31:0] mem_rdata;
   logic        halted;

   // 256 words of text at TEXT_START and 256 words of data at 0
   logic [31:0] imem [256];
   logic [31:0] dmem [256];

   // expected stores in program order
   logic [31:0] exp_addr [MAX_ST];
   logic [31:0] exp_data [MAX_ST];
   logic [31:0] exp_mask [MAX_ST];
   int          s_count;
   int          exp_n;
   int          limit;
   int          cycles;
   int          retired;
   int          st_idx;
   int          halt_cycles;

   mips_core dut_i (
      .clk       (clk),
      .rst_b     (rst_b),
      .inst_addr (inst_addr),
      .inst      (inst),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_wmask (mem_wmask),
      .mem_rdata (mem_rdata),
      .halted    (halted)
   );

   // fetch outside the text window returns a reserved opcode
   assign inst = (inst_addr[29:8] == 22'h00_1000) ? imem[inst_addr[7:0]] : 32'hFFFF_FFFF;
   assign mem_rdata = (mem_addr[29:8] == 22'h0) ? dmem[mem_addr[7:0]] : 32'h0;

   always #2 clk = ~clk;

   task automatic abort_run();
      $display("Something failed");
      $fatal(1, "simulation stopped at %0t ns", $time);
   endtask

   task automatic reject_trace(input string what);
      $display("core_trace.txt is unusable: %s", what);
      abort_run();
   endtask

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected)
      begin
         $display("Error at %0t ns: %s is 0x%08h, expected 0x%08h",
                  $time, name, actual, expected);
         abort_run();
      end
   endtask

   // one record per line, anything after the fields is a comment
   task automatic load_trace();
      int               fd;
      int               c;
      int               got;
      logic [31:0]      a;
      logic [31:0]      d;
      logic [31:0]      m;
      logic [8*160-1:0] rest;
      fd = $fopen("core_trace.txt", "r");
      if (fd == 0)
         reject_trace("cannot open the file");
      c = $fgetc(fd);
      while (c != -1)
      begin
         if (c == CH_INST)
         begin
            got = $fscanf(fd, "%h %h", a, d);
            if (got != 2 || a[29:8] != 22'h00_1000)
               reject_trace("bad instruction record");
            imem[a[7:0]] = d;
         end
         else if (c == CH_DATA)
         begin
            got = $fscanf(fd, "%h %h", a, d);
            if (got != 2 || a[29:8] != 22'h0)
               reject_trace("bad data record");
            dmem[a[7:0]] = d;
         end
         else if (c == CH_STORE)
         begin
            got = $fscanf(fd, "%h %h %h", a, d, m);
            if (got != 3 || s_count >= MAX_ST)
               reject_trace("bad store record or too many stores");
            exp_addr[s_count] = a;
            exp_data[s_count] = d;
            exp_mask[s_count] = m;
            s_count = s_count + 1;
         end
         else if (c == CH_COUNT)
         begin
            got = $fscanf(fd, "%d", exp_n);
            if (got != 1)
               reject_trace("bad instruction count");
         end
         else if (c != CH_HASH && c != CH_NL)
            reject_trace("unknown record type");
         // drop the rest of the line
         if (c != CH_NL)
            got = $fgets(rest, fd);
         c = $fgetc(fd);
      end
      $fclose(fd);
      if (exp_n <= 0 || s_count == 0)
         reject_trace("no instruction count or no stores");
   endtask

   initial
   begin
      clk         = 1'b0;
      rst_b       = 1'b0;
      s_count     = 0;
      exp_n       = 0;
      cycles      = 0;
      retired     = 0;
      st_idx      = 0;
      halt_cycles = 0;
      for (int i = 0; i < 256; i++)
      begin
         imem[i] = 32'hFFFF_FFFF;
         dmem[i] = 32'h0;
      end
      load_trace();
      // core needs one cycle per instruction, the rest is margin
      limit = 4 * exp_n + 20;
      repeat (5) @(posedge clk);
      rst_b <= 1'b1;
   end

   // outputs seen here still hold the values of the retiring instruction
   always @(posedge clk)
   begin
      if (rst_b)
      begin
         cycles = cycles + 1;
         if (cycles > limit)
         begin
            $display("timeout: core never halted within %0d cycles", limit);
            abort_run();
         end
         if (!halted)
         begin
            retired = retired + 1;
            if (mem_wmask != 4'b0000)
            begin
               if (st_idx >= s_count)
               begin
                  $display("core stored to word 0x%08h beyond the expected list",
                           {2'b00, mem_addr});
                  abort_run();
               end
               check_value("mem_addr", {2'b00, mem_addr}, exp_addr[st_idx]);
               check_value("mem_wdata", mem_wdata, exp_data[st_idx]);
               check_value("mem_wmask", {28'h0, mem_wmask}, exp_mask[st_idx]);
               // merge only the enabled lanes into the data memory
               for (int l = 0; l < 4; l++)
               begin
                  if (mem_wmask[l])
                     dmem[mem_addr[7:0]][8*l +: 8] <= mem_wdata[8*l +: 8];
               end
               st_idx = st_idx + 1;
            end
         end
         else
         begin
            if (mem_wmask != 4'b0000)
            begin
               $display("core stored to memory after it halted");
               abort_run();
            end
            // first halted sample, the syscall was the last retired one
            if (halt_cycles == 0)
            begin
               check_value("instruction count", retired, exp_n);
               check_value("store count", st_idx, s_count);
            end
            halt_cycles = halt_cycles + 1;
            if (halt_cycles == 4)
            begin
               $display("Everything OK");
               $finish;
            end
         end
      end
   end

endmodule

/* core_trace.txt */
# I word_addr inst | D word_addr data | S word_addr data mask | N executed_count
# values in hex except N, word address is the byte address divided by 4
I 00100000 24081234 # addiu t0, zero, 0x1234
I 00100001 3409F0F0 # ori   t1, zero, 0xf0f0
I 00100002 3C0A8001 # lui   t2, 0x8001
I 00100003 010A5821 # addu  t3, t0, t2
I 00100004 AC0B0100 # sw    t3, 0x100(zero)
I 00100005 01096023 # subu  t4, t0, t1
I 00100006 AC0C0104 # sw    t4, 0x104(zero)
I 00100007 01096824 # and   t5, t0, t1
I 00100008 01AA6827 # nor   t5, t5, t2
I 00100009 AC0D0108 # sw    t5, 0x108(zero)
I 0010000A 0148802A # slt   s0, t2, t0
I 0010000B 2911FFFF # slti  s1, t0, -1
I 0010000C AC10010C # sw    s0, 0x10c(zero)
I 0010000D AC110110 # sw    s1, 0x110(zero)
I 0010000E 000A6900 # sll   t5, t2, 4
I 0010000F 000A7202 # srl   t6, t2, 8
I 00100010 000A7A03 # sra   t7, t2, 8
I 00100011 AC0D0114 # sw    t5, 0x114(zero)
I 00100012 AC0E0118 # sw    t6, 0x118(zero)
I 00100013 AC0F011C # sw    t7, 0x11c(zero)
I 00100014 392DFFFF # xori  t5, t1, 0xffff
I 00100015 AC0D0120 # sw    t5, 0x120(zero)
I 00100016 24000055 # addiu zero, zero, 0x55
I 00100017 AC000124 # sw    zero, 0x124(zero)
I 00100018 800E0180 # lb    t6, 0x180(zero)
I 00100019 900F0180 # lbu   t7, 0x180(zero)
I 0010001A AC0E0128 # sw    t6, 0x128(zero)
I 0010001B AC0F012C # sw    t7, 0x12c(zero)
I 0010001C A00B01C0 # sb    t3, 0x1c0(zero)
I 0010001D A00B01C7 # sb    t3, 0x1c7(zero)
I 0010001E 8C0C01C0 # lw    t4, 0x1c0(zero)
I 0010001F AC0C0130 # sw    t4, 0x130(zero)
I 00100020 11080001 # beq   t0, t0, +1
I 00100021 AC0B0134 # sw    t3, 0x134(zero), skipped
I 00100022 15080001 # bne   t0, t0, +1
I 00100023 24110077 # addiu s1, zero, 0x77
I 00100024 AC110138 # sw    s1, 0x138(zero)
I 00100025 24100003 # addiu s0, zero, 3
I 00100026 AC100200 # loop: sw s0, 0x200(zero)
I 00100027 2610FFFF # addiu s0, s0, -1
I 00100028 1E00FFFD # bgtz  s0, loop
I 00100029 0810002B # j     over
I 0010002A AC0B0134 # sw    t3, 0x134(zero), skipped
I 0010002B 0C10002F # over: jal func
I 0010002C AC1F013C # sw    ra, 0x13c(zero)
I 0010002D AC0D0140 # sw    t5, 0x140(zero)
I 0010002E 0000000C # syscall
I 0010002F 240D005A # func: addiu t5, zero, 0x5a
I 00100030 03E00008 # jr    ra
# preloaded data words
D 00000060 80A1B27F
D 00000070 00AABBCC
# expected stores, mask bit 3 is byte offset 0
S 00000040 80011234 f
S 00000041 FFFF2144 f
S 00000042 7FFEEFCF f
S 00000043 00000001 f
S 00000044 00000000 f
S 00000045 00100000 f
S 00000046 00800100 f
S 00000047 FF800100 f
S 00000048 00000F0F f
S 00000049 00000000 f
S 0000004A FFFFFF80 f
S 0000004B 00000080 f
S 00000070 34343434 8
S 00000071 34343434 1
S 0000004C 34AABBCC f
S 0000004E 00000077 f
S 00000080 00000003 f
S 00000080 00000002 f
S 00000080 00000001 f
S 0000004F 004000B0 f
S 00000050 0000005A f
# executed instructions including the syscall
N 53

/* run_sim.sh */
#!/bin/sh
# build the core and testbench with Verilator, run, then scan the log
verilator --binary --timing --assert --top-module tb_top -f project.f -o tb_top_sim \
   > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_top_sim > sim.log 2>&1
status=$?
grep -q "Something failed" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
[ "$status" -eq 0 ] || { echo "simulation exited abnormally, see sim.log"; exit 1; }
echo "simulation passed"

/* project.f */
mips_isa_pkg.sv
core_ctrl_pkg.sv
fetch_unit.sv
decode_ctrl.sv
reg_file.sv
exec_alu.sv
mem_align.sv
mips_core.sv
tb_top.sv
